// File: source/tex_cache_consts.svh
/*
 * texture cache constants
 * sizes and widths shared by the package and the pipeline stages
 */

`ifndef TEX_CACHE_CONSTS_SVH
`define TEX_CACHE_CONSTS_SVH

// texture coordinates
`define TEX_ADDR_X_WIDTH         10
`define TEX_ADDR_Y_WIDTH         10

// block geometry, 4x4 pixels
`define TEX_BLK_SIZE             2
`define TEX_BLK_PIXELS           16

// direct-mapped, 2 index bits from each block axis
`define TEX_INDEX_WIDTH          4
`define TEX_LINES                16

`define TEX_COMPONENT_NUM        3
`define TEX_COMPONENT_DATA_WIDTH 8
`define TEX_PIXEL_WIDTH          24
`define TEX_USER_WIDTH           4
`define TEX_MEM_ADDR_WIDTH       24
`define TEX_BORDER_DATA          24'h000000

`endif

// File: source/tex_cache_pkg.sv
/*
 * texture cache package
 * pixel, coordinate, tag and address types plus the lookup FSM states
 */

`include "tex_cache_consts.svh"

package tex_cache_pkg;

	typedef logic [`TEX_PIXEL_WIDTH-1:0]    pixel_t;
	typedef logic [`TEX_USER_WIDTH-1:0]     user_t;
	typedef logic [`TEX_ADDR_X_WIDTH-1:0]   coord_x_t;
	typedef logic [`TEX_ADDR_Y_WIDTH-1:0]   coord_y_t;

	// block coordinates, coordinate without the in-block bits
	typedef logic [`TEX_ADDR_X_WIDTH-`TEX_BLK_SIZE-1:0] blk_x_t;
	typedef logic [`TEX_ADDR_Y_WIDTH-`TEX_BLK_SIZE-1:0] blk_y_t;

	typedef logic [`TEX_INDEX_WIDTH-1:0]    line_index_t;
	typedef logic [`TEX_ADDR_X_WIDTH+`TEX_ADDR_Y_WIDTH-2*`TEX_BLK_SIZE-`TEX_INDEX_WIDTH-1:0]
		tag_t;
	typedef logic [2*`TEX_BLK_SIZE-1:0]     blk_offset_t;   // row, column
	typedef logic [`TEX_MEM_ADDR_WIDTH-1:0] mem_addr_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_CLEAR,
		ST_FETCH,
		ST_READ
	} lookup_state_e;

endpackage

// File: source/tex_cache_ifs.sv
/*
 * texture cache stage links
 * tex_req_if carries decoded requests from decode to lookup,
 * tex_pix_if carries looked-up pixels from lookup to the output stage
 */

`timescale 1ns/1ps

interface tex_req_if;
	import tex_cache_pkg::*;

	logic        valid;
	logic        ready;
	logic        border;
	line_index_t index;
	tag_t        tag;
	blk_offset_t offset;
	mem_addr_t   mem_base;  // word address of the block
	user_t       user;

	modport src (
		output valid, border, index, tag, offset, mem_base, user,
		input  ready
	);

	modport dst (
		input  valid, border, index, tag, offset, mem_base, user,
		output ready
	);
endinterface

interface tex_pix_if;
	import tex_cache_pkg::*;

	logic   valid;
	logic   ready;
	logic   border;
	pixel_t data;
	user_t  user;

	modport src (
		output valid, border, data, user,
		input  ready
	);

	modport dst (
		input  valid, border, data, user,
		output ready
	);
endinterface

// File: source/tex_addr_decode.sv
/*
 * texture address decode
 * range check against the texture size, split of the block coordinates
 * into line index and tag, and the block's word address in memory.
 * one registered output slot.
 */

`timescale 1ns/1ps
`include "tex_cache_consts.svh"

module tex_addr_decode (
	input  logic                     clk,
	input  logic                     rst,
	input  tex_cache_pkg::mem_addr_t param_addr,
	input  tex_cache_pkg::coord_x_t  param_width,
	input  tex_cache_pkg::coord_y_t  param_height,
	input  tex_cache_pkg::mem_addr_t param_stride,
	input  tex_cache_pkg::user_t     s_aruser,
	input  tex_cache_pkg::coord_x_t  s_araddrx,
	input  tex_cache_pkg::coord_y_t  s_araddry,
	input  logic                     s_arvalid,
	output logic                     s_arready,
	tex_req_if.src                   req
);
	import tex_cache_pkg::*;

	localparam int IDX_HALF = `TEX_INDEX_WIDTH / 2;

	blk_x_t    blk_x;
	blk_y_t    blk_y;
	mem_addr_t blk_base;
	logic      take;

	assign blk_x = s_araddrx[`TEX_ADDR_X_WIDTH-1:`TEX_BLK_SIZE];
	assign blk_y = s_araddry[`TEX_ADDR_Y_WIDTH-1:`TEX_BLK_SIZE];

	// base + row of blocks + block within the row
	assign blk_base = param_addr + mem_addr_t'(blk_y) * param_stride
			+ (mem_addr_t'(blk_x) << (2 * `TEX_BLK_SIZE));

	assign s_arready = !req.valid || req.ready;
	assign take      = s_arvalid && s_arready;

	// ----------------------------------------------------------------------
	// output slot
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			req.valid <= 1'b0;
		end else if (take) begin
			req.valid <= 1'b1;
		end else if (req.ready) begin
			req.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			req.border   <= (s_araddrx >= param_width) || (s_araddry >= param_height);
			req.index    <= {blk_y[IDX_HALF-1:0], blk_x[IDX_HALF-1:0]};
			req.tag      <= {blk_y[$bits(blk_y_t)-1:IDX_HALF], blk_x[$bits(blk_x_t)-1:IDX_HALF]};
			req.offset   <= {s_araddry[`TEX_BLK_SIZE-1:0], s_araddrx[`TEX_BLK_SIZE-1:0]};
			req.mem_base <= blk_base;
			req.user     <= s_aruser;
		end
	end

endmodule

// File: source/tex_cache_lookup.sv
/*
 * texture cache lookup
 * direct-mapped tag test over 16 lines, 16-beat block fill on a miss,
 * 16-cycle clear walk over the valid bits. one request at a time.
 */

`timescale 1ns/1ps
`include "tex_cache_consts.svh"

module tex_cache_lookup (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     clear_start,
	output logic                     clear_busy,
	output logic                     status_hit,
	output logic                     status_miss,
	tex_req_if.dst                   req,
	tex_pix_if.src                   pix,
	output tex_cache_pkg::mem_addr_t m_araddr,
	output logic                     m_arvalid,
	input  logic                     m_arready,
	input  tex_cache_pkg::pixel_t    m_rdata,
	input  logic                     m_rvalid
);
	import tex_cache_pkg::*;

	localparam int MEM_DEPTH = `TEX_LINES * `TEX_BLK_PIXELS;
	localparam int MEM_AW    = $clog2(MEM_DEPTH);

	lookup_state_e         state;
	logic [`TEX_LINES-1:0] tag_valid;
	tag_t                  tag_mem [`TEX_LINES];
	pixel_t                data_mem [MEM_DEPTH];

	// the request being served
	line_index_t hold_index;
	tag_t        hold_tag;
	blk_offset_t hold_offset;
	user_t       hold_user;

	blk_offset_t       beat_cnt;
	line_index_t       clear_cnt;
	logic              clear_pend;
	logic              hit;
	logic              pix_free;
	logic              take;
	logic              read_done;
	logic              pix_load;
	logic              beat_we;
	logic              last_beat;
	logic [MEM_AW-1:0] rd_addr;

	assign hit       = tag_valid[req.index] && (tag_mem[req.index] == req.tag);
	assign pix_free  = !pix.valid || pix.ready;
	assign req.ready = (state == ST_IDLE) && !clear_pend && !clear_start && pix_free;
	assign take      = req.valid && req.ready;
	assign read_done = (state == ST_READ) && pix_free;
	assign pix_load  = (take && (req.border || hit)) || read_done;

	// beats only count once the address has gone out
	assign beat_we   = (state == ST_FETCH) && !m_arvalid && m_rvalid;
	assign last_beat = (beat_cnt == blk_offset_t'(`TEX_BLK_PIXELS - 1));

	assign rd_addr    = (state == ST_READ) ? {hold_index, hold_offset} : {req.index, req.offset};
	assign clear_busy = (state == ST_CLEAR);

	// ----------------------------------------------------------------------
	// control FSM
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= ST_IDLE;
			tag_valid   <= '0;
			clear_pend  <= 1'b0;
			clear_cnt   <= '0;
			beat_cnt    <= '0;
			m_arvalid   <= 1'b0;
			pix.valid   <= 1'b0;
			status_hit  <= 1'b0;
			status_miss <= 1'b0;
		end else begin
			status_hit  <= take && !req.border && hit;
			status_miss <= take && !req.border && !hit;

			if (pix_load) begin
				pix.valid <= 1'b1;
			end else if (pix.ready) begin
				pix.valid <= 1'b0;
			end

			if (clear_start && state != ST_IDLE) begin
				clear_pend <= 1'b1;   // wait for the current item
			end

			case (state)
				ST_IDLE: begin
					if (clear_start || clear_pend) begin
						state      <= ST_CLEAR;
						clear_pend <= 1'b0;
						clear_cnt  <= '0;
					end else if (take && !req.border && !hit) begin
						state     <= ST_FETCH;
						m_arvalid <= 1'b1;
						beat_cnt  <= '0;
					end
				end
				ST_CLEAR: begin
					tag_valid[clear_cnt] <= 1'b0;
					clear_cnt            <= clear_cnt + 1'b1;
					if (clear_cnt == line_index_t'(`TEX_LINES - 1)) begin
						state <= ST_IDLE;
					end
				end
				ST_FETCH: begin
					if (m_arvalid && m_arready) begin
						m_arvalid <= 1'b0;
					end
					if (beat_we) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (last_beat) begin
							tag_valid[hold_index] <= 1'b1;
							state                 <= ST_READ;
						end
					end
				end
				ST_READ: begin
					if (pix_free) state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// memories and payload
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (beat_we) begin
			data_mem[{hold_index, beat_cnt}] <= m_rdata;
		end
		if (beat_we && last_beat) begin
			tag_mem[hold_index] <= hold_tag;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			hold_index  <= req.index;
			hold_tag    <= req.tag;
			hold_offset <= req.offset;
			hold_user   <= req.user;
			m_araddr    <= req.mem_base;   // held while the fill runs
		end
		if (pix_load) begin
			pix.data   <= data_mem[rd_addr];
			pix.border <= read_done ? 1'b0 : req.border;
			pix.user   <= read_done ? hold_user : req.user;
		end
	end

endmodule

// File: source/tex_pixel_out.sv
/*
 * texture pixel output stage
 * border substitution, optional component order reversal,
 * one-entry output register toward the client
 */

`timescale 1ns/1ps
`include "tex_cache_consts.svh"

module tex_pixel_out (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  endian,
	tex_pix_if.dst                pix,
	output tex_cache_pkg::user_t  s_ruser,
	output tex_cache_pkg::pixel_t s_rdata,
	output logic                  s_rvalid,
	input  logic                  s_rready
);
	import tex_cache_pkg::*;

	localparam int CW = `TEX_COMPONENT_DATA_WIDTH;

	pixel_t swapped;
	pixel_t pix_value;
	logic   take;

	// first component ends up last
	always_comb begin
		for (int i = 0; i < `TEX_COMPONENT_NUM; i++) begin
			swapped[i*CW +: CW] = pix.data[(`TEX_COMPONENT_NUM-1-i)*CW +: CW];
		end
	end

	assign pix_value = pix.border ? pixel_t'(`TEX_BORDER_DATA) : (endian ? swapped : pix.data);

	assign pix.ready = !s_rvalid || s_rready;
	assign take      = pix.valid && pix.ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			s_rvalid <= 1'b0;
		end else if (take) begin
			s_rvalid <= 1'b1;
		end else if (s_rready) begin
			s_rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			s_rdata <= pix_value;
			s_ruser <= pix.user;
		end
	end

endmodule

// File: source/tex_cache_top.sv
/*
 * texture cache top level
 * decode -> lookup -> pixel output, plain client and memory ports
 */

`timescale 1ns/1ps

module tex_cache_top (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     endian,
	input  logic                     clear_start,
	output logic                     clear_busy,
	input  tex_cache_pkg::mem_addr_t param_addr,
	input  tex_cache_pkg::coord_x_t  param_width,
	input  tex_cache_pkg::coord_y_t  param_height,
	input  tex_cache_pkg::mem_addr_t param_stride,
	input  tex_cache_pkg::user_t     s_aruser,
	input  tex_cache_pkg::coord_x_t  s_araddrx,
	input  tex_cache_pkg::coord_y_t  s_araddry,
	input  logic                     s_arvalid,
	output logic                     s_arready,
	output tex_cache_pkg::user_t     s_ruser,
	output tex_cache_pkg::pixel_t    s_rdata,
	output logic                     s_rvalid,
	input  logic                     s_rready,
	output logic                     status_hit,
	output logic                     status_miss,
	output tex_cache_pkg::mem_addr_t m_araddr,
	output logic                     m_arvalid,
	input  logic                     m_arready,
	input  tex_cache_pkg::pixel_t    m_rdata,
	input  logic                     m_rvalid
);

	tex_req_if req_if ();
	tex_pix_if pix_if ();

	tex_addr_decode i_addr_decode (
		.clk          (clk),
		.rst          (rst),
		.param_addr   (param_addr),
		.param_width  (param_width),
		.param_height (param_height),
		.param_stride (param_stride),
		.s_aruser     (s_aruser),
		.s_araddrx    (s_araddrx),
		.s_araddry    (s_araddry),
		.s_arvalid    (s_arvalid),
		.s_arready    (s_arready),
		.req          (req_if.src)
	);

	tex_cache_lookup i_cache_lookup (
		.clk         (clk),
		.rst         (rst),
		.clear_start (clear_start),
		.clear_busy  (clear_busy),
		.status_hit  (status_hit),
		.status_miss (status_miss),
		.req         (req_if.dst),
		.pix         (pix_if.src),
		.m_araddr    (m_araddr),
		.m_arvalid   (m_arvalid),
		.m_arready   (m_arready),
		.m_rdata     (m_rdata),
		.m_rvalid    (m_rvalid)
	);

	tex_pixel_out i_pixel_out (
		.clk      (clk),
		.rst      (rst),
		.endian   (endian),
		.pix      (pix_if.dst),
		.s_ruser  (s_ruser),
		.s_rdata  (s_rdata),
		.s_rvalid (s_rvalid),
		.s_rready (s_rready)
	);

endmodule

// File: dv/tb_tex_cache.sv
/*
 * texture cache testbench
 * clock, reset, burst memory model, in-order response monitor and
 * directed tests: miss and hit, eviction, border, clear, endian swap
 * under random back-pressure
 */

`timescale 1ns/1ps

module tb_tex_cache;
	import tex_cache_pkg::*;

	localparam int P_ADDR   = 'h1000;
	localparam int P_WIDTH  = 64;
	localparam int P_HEIGHT = 32;
	localparam int P_STRIDE = 256;

	logic      clk;
	logic      rst;
	logic      endian;
	logic      clear_start;
	logic      clear_busy;
	mem_addr_t param_addr;
	coord_x_t  param_width;
	coord_y_t  param_height;
	mem_addr_t param_stride;
	user_t     s_aruser, s_ruser;
	coord_x_t  s_araddrx;
	coord_y_t  s_araddry;
	logic      s_arvalid, s_arready;
	pixel_t    s_rdata;
	logic      s_rvalid, s_rready;
	logic      status_hit, status_miss;
	mem_addr_t m_araddr;
	logic      m_arvalid, m_arready;
	pixel_t    m_rdata;
	logic      m_rvalid;

	pixel_t    exp_data[$];    // outstanding responses, oldest first
	user_t     exp_user[$];
	int        hit_cnt = 0;
	int        miss_cnt = 0;
	int        ar_cnt = 0;
	mem_addr_t last_araddr;
	logic      bp_on = 1'b0;
	logic      stalled = 1'b0;
	pixel_t    stall_data;
	user_t     stall_user;

	tex_cache_top i_tex_cache_top (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// reference rules and helpers
	// ----------------------------------------------------------------------

	function automatic mem_addr_t blk_base(input int x, input int y);
		return mem_addr_t'(P_ADDR + (y / 4) * P_STRIDE + (x / 4) * 16);
	endfunction

	function automatic mem_addr_t pixel_addr(input int x, input int y);
		return blk_base(x, y) + mem_addr_t'((y % 4) * 4 + x % 4);
	endfunction

	function automatic pixel_t mem_word(input mem_addr_t a);
		return pixel_t'((int'(a) * 40503) ^ 32'h00a5c3f1);
	endfunction

	function automatic pixel_t swap_components(input pixel_t p);
		return {p[7:0], p[15:8], p[23:16]};
	endfunction

	task automatic stop_fail();
		$display("Some tests failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s, got %0h expected %0h", $time, msg, actual, expected);
			stop_fail();
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout at %0t ns while waiting for %s", $time, what);
		stop_fail();
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// ----------------------------------------------------------------------
	// memory model and back-pressure
	// ----------------------------------------------------------------------

	initial begin : mem_model
		mem_addr_t base;
		m_arready = 1'b0;
		m_rvalid  = 1'b0;
		m_rdata   = '0;
		forever begin
			next_cycle();
			if (!rst && m_arvalid) begin
				repeat ($urandom_range(3, 0)) next_cycle();
				base      = m_araddr;
				m_arready = 1'b1;
				next_cycle();
				m_arready = 1'b0;
				for (int k = 0; k < 16; k++) begin
					repeat ($urandom_range(2, 0)) next_cycle();   // gap between beats
					m_rdata  = mem_word(base + mem_addr_t'(k));
					m_rvalid = 1'b1;
					next_cycle();
					m_rvalid = 1'b0;
				end
			end
		end
	end

	initial begin : rready_drive
		s_rready = 1'b1;
		forever begin
			next_cycle();
			s_rready = bp_on ? ($urandom_range(1, 0) == 1) : 1'b1;
		end
	end

	// ----------------------------------------------------------------------
	// monitor, sampled mid-cycle
	// ----------------------------------------------------------------------

	task automatic take_response();
		if (exp_data.size() == 0) begin
			$display("response on s_r at %0t ns with no request outstanding", $time);
			stop_fail();
		end else begin
			check(32'(s_rdata), 32'(exp_data.pop_front()), "s_rdata");
			check(32'(s_ruser), 32'(exp_user.pop_front()), "s_ruser");
		end
	endtask

	always @(negedge clk) begin
		if (!rst) begin
			if (status_hit)
				hit_cnt++;
			if (status_miss)
				miss_cnt++;
			if (m_arvalid && m_arready) begin
				ar_cnt++;
				last_araddr = m_araddr;
			end
			if (stalled) begin
				check(32'(s_rvalid), 32'd1, "s_rvalid held while stalled");
				check(32'(s_rdata), 32'(stall_data), "s_rdata held while stalled");
				check(32'(s_ruser), 32'(stall_user), "s_ruser held while stalled");
			end
			stalled    = s_rvalid && !s_rready;
			stall_data = s_rdata;
			stall_user = s_ruser;
			if (s_rvalid && s_rready)
				take_response();
		end
	end

	// ----------------------------------------------------------------------
	// request driver and waits
	// ----------------------------------------------------------------------

	task automatic send_req(input int x, input int y, input int user);
		pixel_t word;
		logic   sent;
		int     n;
		if (x >= P_WIDTH || y >= P_HEIGHT)
			word = '0;   // border pixel
		else if (endian)
			word = swap_components(mem_word(pixel_addr(x, y)));
		else
			word = mem_word(pixel_addr(x, y));
		exp_data.push_back(word);
		exp_user.push_back(user_t'(user));
		s_araddrx = coord_x_t'(x);
		s_araddry = coord_y_t'(y);
		s_aruser  = user_t'(user);
		s_arvalid = 1'b1;
		sent      = 1'b0;
		n         = 0;
		while (!sent) begin
			@(negedge clk);
			sent = s_arready;
			next_cycle();
			n++;
			if (n > 1000)
				timeout_fail("s_arready");
		end
		s_arvalid = 1'b0;
	endtask

	task automatic wait_responses(input int limit);
		int n;
		n = 0;
		while (exp_data.size() != 0) begin
			next_cycle();
			n++;
			if (n > limit)
				timeout_fail("outstanding responses");
		end
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------

	task automatic test_miss_then_hit();
		int h0;
		int m0;
		int a0;
		h0 = hit_cnt;
		m0 = miss_cnt;
		a0 = ar_cnt;
		send_req(5, 9, 3);
		wait_responses(1000);
		check(miss_cnt - m0, 1, "miss pulses after first access");
		check(hit_cnt - h0, 0, "hit pulses after first access");
		check(ar_cnt - a0, 1, "m_ar transfers after first access");
		check(32'(last_araddr), 32'(blk_base(5, 9)), "m_araddr of the fill");
		send_req(5, 9, 4);
		wait_responses(1000);
		check(hit_cnt - h0, 1, "hit pulses after second access");
		check(miss_cnt - m0, 1, "miss pulses after second access");
		check(ar_cnt - a0, 1, "m_ar transfers after second access");
	endtask

	task automatic test_eviction();
		int m0;
		int a0;
		m0 = miss_cnt;
		a0 = ar_cnt;
		send_req(2, 1, 5);     // block (0,0), line 0
		send_req(18, 17, 6);   // block (4,4), line 0, other tag
		send_req(2, 1, 7);
		wait_responses(2000);
		check(miss_cnt - m0, 3, "miss pulses for eviction");
		check(ar_cnt - a0, 3, "bursts for eviction");
	endtask

	task automatic test_border();
		int s0;
		int a0;
		s0 = hit_cnt + miss_cnt;
		a0 = ar_cnt;
		send_req(70, 3, 8);
		send_req(3, 40, 9);
		wait_responses(500);
		check(hit_cnt + miss_cnt - s0, 0, "status pulses for border requests");
		check(ar_cnt - a0, 0, "m_ar transfers for border requests");
	endtask

	task automatic test_clear();
		int m0;
		int a0;
		int n;
		send_req(40, 20, 10);
		wait_responses(1000);
		m0 = miss_cnt;
		a0 = ar_cnt;
		clear_start = 1'b1;
		next_cycle();
		clear_start = 1'b0;
		check(32'(clear_busy), 32'd1, "clear_busy the cycle after clear_start");
		n = 0;
		while (clear_busy) begin
			next_cycle();
			n++;
			if (n > 100)
				timeout_fail("clear_busy to fall");
		end
		check(n, 16, "clear_busy length in cycles");
		send_req(40, 20, 11);
		wait_responses(1000);
		check(miss_cnt - m0, 1, "miss after clear");
		check(ar_cnt - a0, 1, "refetch after clear");
	endtask

	task automatic test_endian_backpressure();
		int s0;
		int x;
		int y;
		s0     = hit_cnt + miss_cnt;
		endian = 1'b1;
		bp_on  = 1'b1;
		for (int i = 0; i < 20; i++) begin
			x = $urandom_range(P_WIDTH - 1, 0);
			y = $urandom_range(P_HEIGHT - 1, 0);
			send_req(x, y, i % 16);
		end
		wait_responses(6000);
		check(hit_cnt + miss_cnt - s0, 20, "status pulses for the stream");
		bp_on  = 1'b0;
		endian = 1'b0;
	endtask

	initial begin
		void'($urandom(32'h9974_1293));
		rst          = 1'b1;
		endian       = 1'b0;
		clear_start  = 1'b0;
		param_addr   = mem_addr_t'(P_ADDR);
		param_width  = coord_x_t'(P_WIDTH);
		param_height = coord_y_t'(P_HEIGHT);
		param_stride = mem_addr_t'(P_STRIDE);
		s_aruser     = '0;
		s_araddrx    = '0;
		s_araddry    = '0;
		s_arvalid    = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		next_cycle();
		test_miss_then_hit();
		test_eviction();
		test_border();
		test_clear();
		test_endian_backpressure();
		repeat (4) next_cycle();
		if (exp_data.size() == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("%0d responses never arrived", exp_data.size());
			stop_fail();
		end
	end

endmodule

// File: flist.f
+incdir+source
source/tex_cache_pkg.sv
source/tex_cache_ifs.sv
source/tex_addr_decode.sv
source/tex_cache_lookup.sv
source/tex_pixel_out.sv
source/tex_cache_top.sv
dv/tb_tex_cache.sv

// File: run.sh
#!/usr/bin/env bash
# builds the texture cache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary -j 0 --timescale 1ns/1ps --top-module tb_tex_cache \
	-f flist.f -o sim_tex_cache; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_tex_cache 2>&1)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "All tests passed"; then
	exit 0
fi
echo "pass message not found in the simulation output"
exit 1
